// File: include/rob_settings.svh
//////////////////////////////////////////////////////////////////////
// Re-order buffer build settings
// Sizes of the buffer, its data paths and the completion buses
//////////////////////////////////////////////////////////////////////

`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// Number of buffer entries, must be a power of two
`define ROB_DEPTH 8

// Result word width
`define ROB_DATA_WIDTH 32

// Width of the pc and of the branch target address
`define ROB_ADDR_WIDTH 32

// Number of common data buses that write completions
`define ROB_CDB_DEPTH 2

// Architectural register index width
`define ROB_REG_IDX_WIDTH 5

`endif

// File: verilog/rob_pkg.sv
//////////////////////////////////////////////////////////////////////
// Re-order buffer types
// Tag, pointer and payload types plus the per-entry state word
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "rob_settings.svh"

package rob_pkg;

    localparam int ROB_TAG_WIDTH = $clog2(`ROB_DEPTH);

    // Slot index handed to the renamer
    typedef logic [ROB_TAG_WIDTH-1:0] rob_tag_t;

    // Slot index with an extra wrap bit to tell full from empty
    typedef logic [ROB_TAG_WIDTH:0] rob_ptr_t;

    typedef logic [`ROB_DATA_WIDTH-1:0]    rob_data_t;
    typedef logic [`ROB_ADDR_WIDTH-1:0]    rob_addr_t;
    typedef logic [`ROB_REG_IDX_WIDTH-1:0] rob_rdest_t;

    typedef enum logic {
        ROB_OP_INT = 1'b0,
        ROB_OP_BR  = 1'b1
    } rob_op_t;

    // What one slot shows to the retire logic
    typedef struct packed {
        logic       ready;
        logic       redirect;
        rob_op_t    op;
        rob_addr_t  pc;
        rob_addr_t  addr;
        rob_data_t  data;
        rob_rdest_t rdest;
    } rob_entry_t;

endpackage

`default_nettype wire

// File: verilog/rob_cdb_if.sv
//////////////////////////////////////////////////////////////////////
// Completion bus bundle
// One strobe, redirect flag, data, target and tag per common data bus
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "rob_settings.svh"

interface rob_cdb_if import rob_pkg::*; ();

    logic      en       [0:`ROB_CDB_DEPTH-1];
    logic      redirect [0:`ROB_CDB_DEPTH-1];
    rob_data_t data     [0:`ROB_CDB_DEPTH-1];
    rob_addr_t addr     [0:`ROB_CDB_DEPTH-1];
    rob_tag_t  tag      [0:`ROB_CDB_DEPTH-1];

    // Execution side puts completions on the buses
    modport source (
        output en,
        output redirect,
        output data,
        output addr,
        output tag
    );

    // Buffer slots watch the buses for their own tag
    modport sink (
        input en,
        input redirect,
        input data,
        input addr,
        input tag
    );

endinterface

`default_nettype wire

// File: verilog/rob_pointers.sv
//////////////////////////////////////////////////////////////////////
// Re-order buffer pointer control
// Head and tail pointers, full and empty flags, dispatch fill select
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "rob_settings.svh"

module rob_pointers import rob_pkg::*; (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  i_rename_en,
    input  logic                  i_enq_en,
    input  logic                  i_retire_adv,
    input  logic                  i_flush,
    output rob_tag_t              o_rename_tag,
    output rob_tag_t              o_head_tag,
    output logic [`ROB_DEPTH-1:0] o_enq_sel,
    output logic                  o_empty,
    output logic                  o_full
);

    rob_ptr_t              head_q;
    rob_ptr_t              tail_q;
    rob_ptr_t              head_next;
    rob_ptr_t              tail_next;
    rob_tag_t              head_tag;
    rob_tag_t              tail_tag;
    logic                  rename_ok;
    logic                  empty_q;
    logic [`ROB_DEPTH-1:0] enq_sel_q;

    assign head_tag  = head_q[ROB_TAG_WIDTH-1:0];
    assign tail_tag  = tail_q[ROB_TAG_WIDTH-1:0];

    // A rename is only taken when there is room for it
    assign rename_ok = i_rename_en & ~o_full;

    assign tail_next = i_flush ? '0 : (rename_ok ? tail_q + 1'b1 : tail_q);
    assign head_next = i_flush ? '0 : (i_retire_adv ? head_q + 1'b1 : head_q);

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            head_q <= head_next;
            tail_q <= tail_next;
        end
    end

    // Full when the pointers differ only in the wrap bit
    always_ff @(posedge clk) begin
        if (!n_rst || i_flush) begin
            o_full  <= 1'b0;
            empty_q <= 1'b1;
        end else begin
            o_full  <= ({~tail_next[ROB_TAG_WIDTH], tail_next[ROB_TAG_WIDTH-1:0]} == head_next);
            empty_q <= (tail_next == head_next);
        end
    end

    // Remember which slot the last accepted rename reserved
    // The dispatcher fills it in the cycle that follows
    always_ff @(posedge clk) begin
        if (!n_rst || i_flush) begin
            enq_sel_q <= '0;
        end else if (rename_ok) begin
            enq_sel_q <= {{(`ROB_DEPTH-1){1'b0}}, 1'b1} << tail_tag;
        end else begin
            enq_sel_q <= '0;
        end
    end

    assign o_enq_sel    = enq_sel_q & {`ROB_DEPTH{i_enq_en}};
    assign o_rename_tag = tail_tag;
    assign o_head_tag   = head_tag;

    // A slot that is reserved but not yet filled still holds the state of
    // its previous occupant, so it must not look retirable at the head
    assign o_empty = empty_q | enq_sel_q[head_tag];

endmodule

`default_nettype wire

// File: verilog/rob_entry.sv
//////////////////////////////////////////////////////////////////////
// Re-order buffer slot
// Holds one instruction and captures completions for its own tag
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "rob_settings.svh"

module rob_entry import rob_pkg::*; #(
    parameter int ENTRY_IDX = 0
) (
    input  logic       clk,
    input  logic       n_rst,
    input  logic       i_enq_wr,
    input  rob_op_t    i_enq_op,
    input  rob_addr_t  i_enq_pc,
    input  rob_rdest_t i_enq_rdest,
    input  logic       i_flush,
    rob_cdb_if.sink    cdb,
    output rob_entry_t o_state
);

    logic                     ready_q;
    logic                     redirect_q;
    rob_op_t                  op_q;
    rob_addr_t                pc_q;
    rob_addr_t                addr_q;
    rob_data_t                data_q;
    rob_rdest_t               rdest_q;
    logic                     ready_nxt;
    logic                     redirect_nxt;
    rob_addr_t                addr_nxt;
    rob_data_t                data_nxt;
    logic [`ROB_CDB_DEPTH-1:0] hit;

    always_comb begin
        for (int b = 0; b < `ROB_CDB_DEPTH; b++) begin
            hit[b] = cdb.en[b] & (cdb.tag[b] == rob_tag_t'(ENTRY_IDX));
        end
    end

    // Later buses override earlier ones when they name the same tag
    always_comb begin
        ready_nxt    = ready_q;
        redirect_nxt = redirect_q;
        addr_nxt     = addr_q;
        data_nxt     = data_q;
        for (int b = 0; b < `ROB_CDB_DEPTH; b++) begin
            if (hit[b]) begin
                ready_nxt    = 1'b1;
                redirect_nxt = cdb.redirect[b];
                addr_nxt     = cdb.addr[b];
                data_nxt     = cdb.data[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        data_q <= data_nxt;
        addr_q <= addr_nxt;
        if (i_enq_wr) begin
            op_q    <= i_enq_op;
            pc_q    <= i_enq_pc;
            rdest_q <= i_enq_rdest;
        end
    end

    // A new fill starts the slot over as not yet completed
    always_ff @(posedge clk) begin
        if (!n_rst || i_flush || i_enq_wr) begin
            ready_q    <= 1'b0;
            redirect_q <= 1'b0;
        end else begin
            ready_q    <= ready_nxt;
            redirect_q <= redirect_nxt;
        end
    end

    assign o_state = '{
        ready:    ready_q,
        redirect: redirect_q,
        op:       op_q,
        pc:       pc_q,
        addr:     addr_q,
        data:     data_q,
        rdest:    rdest_q
    };

endmodule

`default_nettype wire

// File: verilog/rob_retire.sv
//////////////////////////////////////////////////////////////////////
// Re-order buffer retirement
// Drains the head slot in program order and raises redirects
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "rob_settings.svh"

module rob_retire import rob_pkg::*; (
    input  logic       clk,
    input  logic       n_rst,
    input  rob_entry_t i_entries [0:`ROB_DEPTH-1],
    input  rob_tag_t   i_head_tag,
    input  logic       i_empty,
    output logic       o_retire_adv,
    output logic       o_flush,
    output logic       o_retire_en,
    output rob_data_t  o_retire_data,
    output rob_rdest_t o_retire_rdest,
    output rob_tag_t   o_retire_tag,
    output rob_addr_t  o_redirect_addr
);

    rob_entry_t head;

    assign head = i_entries[i_head_tag];

    // Nothing retires in the flush cycle, the whole buffer is dropped then
    assign o_retire_adv = head.ready & ~i_empty & ~o_flush;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_retire_en <= 1'b0;
            o_flush     <= 1'b0;
        end else begin
            o_retire_en <= o_retire_adv;
            o_flush     <= o_retire_adv & head.redirect;
        end
    end

    // Branches jump to their target, anything else restarts at its own pc
    always_ff @(posedge clk) begin
        o_retire_data   <= head.data;
        o_retire_rdest  <= head.rdest;
        o_retire_tag    <= i_head_tag;
        o_redirect_addr <= (head.op == ROB_OP_BR) ? head.addr : head.pc;
    end

endmodule

`default_nettype wire

// File: verilog/reorder_buffer.sv
//////////////////////////////////////////////////////////////////////
// Re-order buffer top level
// Reserves slots at rename, fills them at dispatch, collects
// completions and retires results to the register map in order
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "rob_settings.svh"

module reorder_buffer import rob_pkg::*; (
    input  logic       clk,
    input  logic       n_rst,

    // Rename reserves the tail slot and gets its tag back
    input  logic       i_rename_en,
    output rob_tag_t   o_rename_tag,

    // Dispatch fills the reserved slot one cycle later
    input  logic       i_enq_en,
    input  rob_op_t    i_enq_op,
    input  rob_addr_t  i_enq_pc,
    input  rob_rdest_t i_enq_rdest,

    // Common data buses
    input  logic       i_cdb_en       [0:`ROB_CDB_DEPTH-1],
    input  logic       i_cdb_redirect [0:`ROB_CDB_DEPTH-1],
    input  rob_data_t  i_cdb_data     [0:`ROB_CDB_DEPTH-1],
    input  rob_addr_t  i_cdb_addr     [0:`ROB_CDB_DEPTH-1],
    input  rob_tag_t   i_cdb_tag      [0:`ROB_CDB_DEPTH-1],

    // Register map update
    output logic       o_retire_en,
    output rob_data_t  o_retire_data,
    output rob_rdest_t o_retire_rdest,
    output rob_tag_t   o_retire_tag,

    // Fetch redirect
    output logic       o_redirect,
    output rob_addr_t  o_redirect_addr,

    output logic       o_rob_stall
);

    logic                  retire_adv;
    logic                  empty;
    rob_tag_t              head_tag;
    logic [`ROB_DEPTH-1:0] enq_sel;
    rob_entry_t            entry_state [0:`ROB_DEPTH-1];

    rob_cdb_if cdb ();

    assign cdb.en       = i_cdb_en;
    assign cdb.redirect = i_cdb_redirect;
    assign cdb.data     = i_cdb_data;
    assign cdb.addr     = i_cdb_addr;
    assign cdb.tag      = i_cdb_tag;

    rob_pointers ptrs0 (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_rename_en  (i_rename_en),
        .i_enq_en     (i_enq_en),
        .i_retire_adv (retire_adv),
        .i_flush      (o_redirect),
        .o_rename_tag (o_rename_tag),
        .o_head_tag   (head_tag),
        .o_enq_sel    (enq_sel),
        .o_empty      (empty),
        .o_full       (o_rob_stall)
    );

    for (genvar i = 0; i < `ROB_DEPTH; i++) begin : g_entry
        rob_entry #(
            .ENTRY_IDX (i)
        ) entry0 (
            .clk         (clk),
            .n_rst       (n_rst),
            .i_enq_wr    (enq_sel[i]),
            .i_enq_op    (i_enq_op),
            .i_enq_pc    (i_enq_pc),
            .i_enq_rdest (i_enq_rdest),
            .i_flush     (o_redirect),
            .cdb         (cdb),
            .o_state     (entry_state[i])
        );
    end

    rob_retire retire0 (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_entries       (entry_state),
        .i_head_tag      (head_tag),
        .i_empty         (empty),
        .o_retire_adv    (retire_adv),
        .o_flush         (o_redirect),
        .o_retire_en     (o_retire_en),
        .o_retire_data   (o_retire_data),
        .o_retire_rdest  (o_retire_rdest),
        .o_retire_tag    (o_retire_tag),
        .o_redirect_addr (o_redirect_addr)
    );

endmodule

`default_nettype wire

// File: bench/tb_reorder_buffer.sv
//////////////////////////////////////////////////////////////////////
// Re-order buffer testbench
// Directed tests against a reference queue of allocated slots
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "rob_settings.svh"

module tb_reorder_buffer import rob_pkg::*; ();

    logic       clk = 1'b0;
    logic       n_rst;
    logic       rename_en;
    rob_tag_t   rename_tag;
    logic       enq_en;
    rob_op_t    enq_op;
    rob_addr_t  enq_pc;
    rob_rdest_t enq_rdest;
    logic       cdb_en       [0:`ROB_CDB_DEPTH-1];
    logic       cdb_redirect [0:`ROB_CDB_DEPTH-1];
    rob_data_t  cdb_data     [0:`ROB_CDB_DEPTH-1];
    rob_addr_t  cdb_addr     [0:`ROB_CDB_DEPTH-1];
    rob_tag_t   cdb_tag      [0:`ROB_CDB_DEPTH-1];
    logic       retire_en;
    rob_data_t  retire_data;
    rob_rdest_t retire_rdest;
    rob_tag_t   retire_tag;
    logic       redirect;
    rob_addr_t  redirect_addr;
    logic       rob_stall;

    integer     seed = 32'h868b;
    int         mismatches = 0;
    int         failures = 0;
    rob_tag_t   model_tail = '0;
    rob_tag_t   order [$];
    rob_data_t  exp_data  [0:`ROB_DEPTH-1];
    rob_rdest_t exp_rdest [0:`ROB_DEPTH-1];

    always #4 clk = ~clk;

    reorder_buffer dut0 (
        .clk (clk), .n_rst (n_rst),
        .i_rename_en (rename_en), .o_rename_tag (rename_tag),
        .i_enq_en (enq_en), .i_enq_op (enq_op),
        .i_enq_pc (enq_pc), .i_enq_rdest (enq_rdest),
        .i_cdb_en (cdb_en), .i_cdb_redirect (cdb_redirect),
        .i_cdb_data (cdb_data), .i_cdb_addr (cdb_addr), .i_cdb_tag (cdb_tag),
        .o_retire_en (retire_en), .o_retire_data (retire_data),
        .o_retire_rdest (retire_rdest), .o_retire_tag (retire_tag),
        .o_redirect (redirect), .o_redirect_addr (redirect_addr),
        .o_rob_stall (rob_stall)
    );

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_tag(string name, rob_tag_t got, rob_tag_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_data(string name, rob_data_t got, rob_data_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_rdest(string name, rob_rdest_t got, rob_rdest_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(string name, rob_addr_t got, rob_addr_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Rename one slot, then fill it in the following cycle
    task automatic allocate(rob_op_t op, rob_addr_t pc, rob_rdest_t rdest,
                            output rob_tag_t tag);
        check_flag("o_rob_stall", rob_stall, 1'b0);
        check_tag("o_rename_tag", rename_tag, model_tail);
        tag       = model_tail;
        rename_en = 1'b1;
        @(negedge clk);
        rename_en = 1'b0;
        enq_en    = 1'b1;
        enq_op    = op;
        enq_pc    = pc;
        enq_rdest = rdest;
        @(negedge clk);
        enq_en    = 1'b0;
        model_tail++;
        order.push_back(tag);
        exp_rdest[tag] = rdest;
    endtask

    // Puts a completion on one bus; bus_cycle lets it take effect
    task automatic complete(int bus, rob_tag_t tag, logic redir, rob_addr_t addr);
        cdb_en[bus]       = 1'b1;
        cdb_redirect[bus] = redir;
        cdb_tag[bus]      = tag;
        cdb_addr[bus]     = addr;
        cdb_data[bus]     = $random(seed);
        exp_data[tag]     = cdb_data[bus];
    endtask

    task automatic bus_cycle();
        @(negedge clk);
        for (int b = 0; b < `ROB_CDB_DEPTH; b++) begin
            cdb_en[b]       = 1'b0;
            cdb_redirect[b] = 1'b0;
        end
    endtask

    // The next retirement must be the oldest slot still in the queue
    task automatic expect_retire(logic exp_redirect);
        rob_tag_t tag;
        int       n;
        tag = order.pop_front();
        n   = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!retire_en && n < 50);
        if (!retire_en) begin
            failures++;
            $display("Timeout at %0t: tag %0d was never retired", $time, tag);
        end else begin
            check_tag("o_retire_tag", retire_tag, tag);
            check_rdest("o_retire_rdest", retire_rdest, exp_rdest[tag]);
            check_data("o_retire_data", retire_data, exp_data[tag]);
            check_flag("o_redirect", redirect, exp_redirect);
        end
    endtask

    task automatic expect_quiet(int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (retire_en) begin
                failures++;
                $display("Unexpected retirement of tag %0d at %0t", retire_tag, $time);
            end
        end
    endtask

    // A redirect empties the buffer and restarts allocation at slot 0
    task automatic flush_model();
        order.delete();
        model_tail = '0;
    endtask

    task automatic test_reset();
        check_flag("o_rob_stall", rob_stall, 1'b0);
        check_flag("o_retire_en", retire_en, 1'b0);
        check_flag("o_redirect", redirect, 1'b0);
        check_tag("o_rename_tag", rename_tag, '0);
    endtask

    task automatic test_in_order();
        rob_tag_t t [0:2];
        for (int i = 0; i < 3; i++) begin
            allocate(ROB_OP_INT, 32'h100 + 4 * i, rob_rdest_t'(i + 1), t[i]);
        end
        for (int i = 2; i >= 0; i--) begin
            complete(0, t[i], 1'b0, '0);
            bus_cycle();
        end
        repeat (3) expect_retire(1'b0);
    endtask

    task automatic test_two_buses();
        rob_tag_t t0;
        rob_tag_t t1;
        allocate(ROB_OP_INT, 32'h200, rob_rdest_t'(4), t0);
        allocate(ROB_OP_INT, 32'h204, rob_rdest_t'(5), t1);
        complete(0, t1, 1'b0, '0);
        complete(1, t0, 1'b0, '0);
        bus_cycle();
        repeat (2) expect_retire(1'b0);
    endtask

    task automatic test_full();
        rob_tag_t t;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            allocate(ROB_OP_INT, 32'h1000 + 4 * i, rob_rdest_t'(i + 10), t);
        end
        check_flag("o_rob_stall", rob_stall, 1'b1);
        rename_en = 1'b1;
        @(negedge clk);
        rename_en = 1'b0;
        check_tag("o_rename_tag", rename_tag, model_tail);
        // Youngest pairs first so the head completes last
        for (int i = `ROB_DEPTH - 1; i > 0; i -= 2) begin
            complete(0, order[i], 1'b0, '0);
            complete(1, order[i-1], 1'b0, '0);
            bus_cycle();
        end
        repeat (`ROB_DEPTH) expect_retire(1'b0);
        expect_quiet(8);
        check_flag("o_rob_stall", rob_stall, 1'b0);
    endtask

    task automatic test_branch_redirect();
        rob_tag_t  br;
        rob_tag_t  y0;
        rob_tag_t  y1;
        rob_tag_t  y2;
        rob_addr_t target;
        target = $random(seed);
        allocate(ROB_OP_BR, 32'h2000, rob_rdest_t'(7), br);
        allocate(ROB_OP_INT, 32'h2004, rob_rdest_t'(8), y0);
        allocate(ROB_OP_INT, 32'h2008, rob_rdest_t'(9), y1);
        allocate(ROB_OP_INT, 32'h200c, rob_rdest_t'(10), y2);
        complete(0, y0, 1'b0, '0);
        complete(1, y1, 1'b0, '0);
        bus_cycle();
        complete(0, br, 1'b1, target);
        complete(1, y2, 1'b0, '0);
        bus_cycle();
        expect_retire(1'b1);
        check_addr("o_redirect_addr", redirect_addr, target);
        flush_model();
        expect_quiet(10);
        check_tag("o_rename_tag", rename_tag, '0);
    endtask

    task automatic test_int_redirect();
        rob_tag_t t;
        allocate(ROB_OP_INT, 32'h3000, rob_rdest_t'(3), t);
        complete(1, t, 1'b1, 32'h3abc);
        bus_cycle();
        expect_retire(1'b1);
        check_addr("o_redirect_addr", redirect_addr, 32'h3000);
        flush_model();
        expect_quiet(4);
        check_tag("o_rename_tag", rename_tag, '0);
    endtask

    initial begin
        n_rst     = 1'b0;
        rename_en = 1'b0;
        enq_en    = 1'b0;
        enq_op    = ROB_OP_INT;
        enq_pc    = '0;
        enq_rdest = '0;
        for (int b = 0; b < `ROB_CDB_DEPTH; b++) begin
            cdb_en[b]       = 1'b0;
            cdb_redirect[b] = 1'b0;
            cdb_data[b]     = '0;
            cdb_addr[b]     = '0;
            cdb_tag[b]      = '0;
        end
        repeat (10) @(negedge clk);
        n_rst = 1'b1;
        @(negedge clk);
        test_reset();
        test_in_order();
        test_two_buses();
        test_full();
        test_branch_redirect();
        test_int_redirect();
        $display("Mismatches: %0d, other failures: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: reorder_buffer.f
+incdir+include
verilog/rob_pkg.sv
verilog/rob_cdb_if.sv
verilog/rob_pointers.sv
verilog/rob_entry.sv
verilog/rob_retire.sv
verilog/reorder_buffer.sv
bench/tb_reorder_buffer.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the re-order buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_reorder_buffer \
    -f reorder_buffer.f

out=$(./obj_dir/Vtb_reorder_buffer)
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
